// File: logic/adc_pkg.sv
package adc_pkg;

  ////////////////////////////////////////
  // widths

  // long counts: aperture, signal, pos/neg dwell
  localparam int CNT_W = 32;
  // reset, fix, var and rundown counts
  localparam int SHORT_W = 24;

  ////////////////////////////////////////
  // reference mux

  // code view, used by the dwell counters
  typedef enum logic [2:0] {
    REFMUX_NONE     = 3'b000,
    REFMUX_POS      = 3'b001,
    REFMUX_NEG      = 3'b010,
    // both reference switches closed
    REFMUX_SLOW_POS = 3'b011,
    REFMUX_RESET    = 3'b100
  } refmux_code_e;

  // switch view, bit order matches the code above
  typedef struct packed {
    logic reset_sw;
    logic neg_sw;
    logic pos_sw;
  } refmux_sw_s;

  // one word, two decodings
  typedef union packed {
    refmux_code_e code;
    refmux_sw_s   sw;
  } refmux_u;

  ////////////////////////////////////////
  // sequencer states

  typedef enum logic [4:0] {
    ST_DONE,
    ST_RESET_START,
    ST_RESET,
    ST_SIG_START,
    ST_FIX_POS_START,
    ST_FIX_POS,
    ST_VAR_START,
    ST_VAR,
    ST_FIX_NEG_START,
    ST_FIX_NEG,
    ST_VAR2_START,
    ST_VAR2,
    ST_FAST_ABOVE,
    ST_FAST_BELOW,
    ST_RUNDOWN_START,
    ST_RUNDOWN
  } mod_state_e;

endpackage

// File: logic/mod_ctl_if.sv
`timescale 1ns/1ps

interface mod_ctl_if
  import adc_pkg::*;
#(
  parameter int CNT_W
) ();

  // reference mux word, from the sequencer
  refmux_u refmux;

  // one-cycle strobes from the sequencer
  logic sig_start;
  logic reset_start;
  logic capture;

  // signal gate and its clock count
  logic sigmux;
  logic [CNT_W-1:0] sig_count;

  modport fsm (
    output refmux,
    output sig_start,
    output reset_start,
    output capture,
    input  sigmux
  );

  modport aperture (
    input  sig_start,
    input  reset_start,
    output sigmux,
    output sig_count
  );

  modport counters (
    input refmux,
    input sig_start,
    input reset_start,
    input capture,
    input sig_count
  );

endinterface

// File: logic/modulation_fsm.sv
`timescale 1ns/1ps

module modulation_fsm
  import adc_pkg::*;
(
  input  logic               clk,
  input  logic               cmpr_latch_val,
  input  logic               adc_measure_trig,
  input  logic               cmpr_val,
  input  logic [SHORT_W-1:0] p_clk_count_reset,
  input  logic [SHORT_W-1:0] p_clk_count_fix,
  input  logic [SHORT_W-1:0] p_clk_count_var,
  input  logic               p_use_slow_rundown,
  input  logic               p_use_fast_rundown,
  output logic               adc_measure_valid,
  mod_ctl_if.fsm             ctl
);

  mod_state_e state;
  refmux_u refmux_q;

  // phase timer, free running down count
  logic [SHORT_W-1:0] phase_timer;
  logic timer_done;

  // comparator sync chain, [1] is the usable level
  logic [2:0] cmpr_sync;
  // high means integrator below zero
  logic cmpr_below;
  logic cmpr_cross_any;

  assign timer_done     = (phase_timer == '0);
  assign cmpr_below     = cmpr_sync[1];
  assign cmpr_cross_any = cmpr_sync[1] ^ cmpr_sync[2];

  ////////////////////////////////////////
  // comparator synchronizer

  always_ff @(posedge clk or negedge cmpr_latch_val)
  begin
    if (!cmpr_latch_val)
      cmpr_sync <= '0;
    else
      cmpr_sync <= {cmpr_sync[1:0], cmpr_val};
  end

  ////////////////////////////////////////
  // sequencer

  always_ff @(posedge clk or negedge cmpr_latch_val)
  begin
    if (!cmpr_latch_val)
    begin
      state             <= ST_DONE;
      refmux_q.code     <= REFMUX_RESET;
      adc_measure_valid <= 1'b1;
      phase_timer       <= '0;
    end
    else
    begin
      // reloaded by the start states below
      phase_timer <= phase_timer - 1'b1;

      case (state)
        ST_DONE:
        begin
          // park, integrator held in reset
          adc_measure_valid <= 1'b1;
          refmux_q.code     <= REFMUX_RESET;
        end
        ST_RESET_START:
        begin
          adc_measure_valid <= 1'b0;
          refmux_q.code     <= REFMUX_RESET;
          phase_timer       <= p_clk_count_reset;
          state             <= ST_RESET;
        end
        ST_RESET:
          if (timer_done)
            state <= ST_SIG_START;
        ST_SIG_START:
        begin
          // release reset, gate opens in aperture_ctl
          refmux_q.code <= REFMUX_NONE;
          state         <= ST_FIX_POS_START;
        end
        ST_FIX_POS_START:
        begin
          refmux_q.code <= REFMUX_POS;
          phase_timer   <= p_clk_count_fix;
          state         <= ST_FIX_POS;
        end
        ST_FIX_POS:
          if (timer_done)
            state <= ST_VAR_START;
        ST_VAR_START:
        begin
          // below zero, push up with neg ref
          refmux_q.code <= cmpr_below ? REFMUX_NEG : REFMUX_POS;
          phase_timer   <= p_clk_count_var;
          state         <= ST_VAR;
        end
        ST_VAR:
          if (timer_done)
            state <= ST_FIX_NEG_START;
        ST_FIX_NEG_START:
        begin
          refmux_q.code <= REFMUX_NEG;
          phase_timer   <= p_clk_count_fix;
          state         <= ST_FIX_NEG;
        end
        ST_FIX_NEG:
          if (timer_done)
            state <= ST_VAR2_START;
        ST_VAR2_START:
        begin
          refmux_q.code <= cmpr_below ? REFMUX_NEG : REFMUX_POS;
          phase_timer   <= p_clk_count_var;
          state         <= ST_VAR2;
        end
        ST_VAR2:
          if (timer_done)
          begin
            // runup ends only once the aperture has closed
            if (ctl.sigmux)
              state <= ST_FIX_POS_START;
            else if (p_use_fast_rundown)
              state <= cmpr_below ? ST_FAST_BELOW : ST_FAST_ABOVE;
            // last var was an up phase and we sit above zero
            else if (refmux_q.code == REFMUX_NEG && !cmpr_below)
              state <= ST_RUNDOWN_START;
            else
              state <= ST_FIX_POS_START;
          end
        ST_FAST_ABOVE:
        begin
          // drive down until below zero
          refmux_q.code <= REFMUX_POS;
          if (cmpr_below)
            state <= ST_FAST_BELOW;
        end
        ST_FAST_BELOW:
        begin
          // drive up until just above zero
          refmux_q.code <= REFMUX_NEG;
          if (!cmpr_below)
            state <= ST_RUNDOWN_START;
        end
        ST_RUNDOWN_START:
        begin
          refmux_q.code <= p_use_slow_rundown ? REFMUX_SLOW_POS : REFMUX_POS;
          state         <= ST_RUNDOWN;
        end
        ST_RUNDOWN:
          if (cmpr_cross_any)
          begin
            // zero cross, measurement complete
            adc_measure_valid <= 1'b1;
            refmux_q.code     <= REFMUX_RESET;
            state             <= ST_DONE;
          end
        default:
          state <= ST_DONE;
      endcase

      // trigger restarts from any state
      if (adc_measure_trig)
        state <= ST_RESET_START;
    end
  end

  ////////////////////////////////////////
  // control strobes, decoded from state

  assign ctl.refmux      = refmux_q;
  assign ctl.reset_start = (state == ST_RESET_START);
  assign ctl.sig_start   = (state == ST_SIG_START);
  assign ctl.capture     = (state == ST_RUNDOWN) && cmpr_cross_any;

endmodule

// File: logic/aperture_ctl.sv
`timescale 1ns/1ps

module aperture_ctl #(
  parameter int CNT_W
) (
  input  logic             clk,
  input  logic             cmpr_latch_val,
  input  logic [CNT_W-1:0] p_clk_count_aperture,
  mod_ctl_if.aperture      ctl
);

  logic sig_on;
  logic [CNT_W-1:0] sig_count;
  // compared before the increment, so the final count is aperture + 1
  logic aperture_end;

  assign aperture_end = (sig_count >= p_clk_count_aperture);

  always_ff @(posedge clk or negedge cmpr_latch_val)
  begin
    if (!cmpr_latch_val)
    begin
      sig_on    <= 1'b0;
      sig_count <= '0;
    end
    else
    begin
      // count every clock the gate is open
      if (sig_on)
      begin
        sig_count <= sig_count + 1'b1;
        if (aperture_end)
          sig_on <= 1'b0;
      end

      // new measurement closes the gate
      if (ctl.reset_start)
        sig_on <= 1'b0;

      // start of runup, open and restart the count
      if (ctl.sig_start)
      begin
        sig_on    <= 1'b1;
        sig_count <= '0;
      end
    end
  end

  assign ctl.sigmux    = sig_on;
  assign ctl.sig_count = sig_count;

endmodule

// File: logic/dwell_counters.sv
`timescale 1ns/1ps

module dwell_counters
  import adc_pkg::*;
#(
  parameter int CNT_W
) (
  input  logic               clk,
  input  logic               cmpr_latch_val,
  mod_ctl_if.counters        ctl,
  output logic [SHORT_W-1:0] clk_count_refmux_reset_last,
  output logic [CNT_W-1:0]   clk_count_refmux_neg_last,
  output logic [CNT_W-1:0]   clk_count_refmux_pos_last,
  output logic [SHORT_W-1:0] clk_count_refmux_rd_last,
  output logic [CNT_W-1:0]   clk_count_mux_sig_last
);

  // live dwell counts per mux code
  logic [SHORT_W-1:0] cnt_reset;
  logic [CNT_W-1:0]   cnt_neg;
  logic [CNT_W-1:0]   cnt_pos;
  logic [SHORT_W-1:0] cnt_rd;

  ////////////////////////////////////////
  // dwell counting

  always_ff @(posedge clk or negedge cmpr_latch_val)
  begin
    if (!cmpr_latch_val)
    begin
      cnt_reset <= '0;
      cnt_neg   <= '0;
      cnt_pos   <= '0;
      cnt_rd    <= '0;
    end
    else
    begin
      case (ctl.refmux.code)
        REFMUX_RESET:    cnt_reset <= cnt_reset + 1'b1;
        REFMUX_NEG:      cnt_neg   <= cnt_neg + 1'b1;
        REFMUX_POS:      cnt_pos   <= cnt_pos + 1'b1;
        REFMUX_SLOW_POS: cnt_rd    <= cnt_rd + 1'b1;
        // none is not counted
        default:         ;
      endcase

      // clears win over the increment
      if (ctl.reset_start)
        cnt_reset <= '0;

      if (ctl.sig_start)
      begin
        cnt_neg <= '0;
        cnt_pos <= '0;
        cnt_rd  <= '0;
      end
    end
  end

  ////////////////////////////////////////
  // snapshot at end of rundown

  always_ff @(posedge clk or negedge cmpr_latch_val)
  begin
    if (!cmpr_latch_val)
    begin
      clk_count_refmux_reset_last <= '0;
      clk_count_refmux_neg_last   <= '0;
      clk_count_refmux_pos_last   <= '0;
      clk_count_refmux_rd_last    <= '0;
      clk_count_mux_sig_last      <= '0;
    end
    else if (ctl.capture)
    begin
      // held until the next capture
      clk_count_refmux_reset_last <= cnt_reset;
      clk_count_refmux_neg_last   <= cnt_neg;
      clk_count_refmux_pos_last   <= cnt_pos;
      clk_count_refmux_rd_last    <= cnt_rd;
      clk_count_mux_sig_last      <= ctl.sig_count;
    end
  end

endmodule

// File: logic/adc_mod_top.sv
`timescale 1ns/1ps

module adc_mod_top
  import adc_pkg::*;
#(
  parameter int CNT_W = adc_pkg::CNT_W
) (
  input  logic               clk,
  input  logic               cmpr_latch_val,
  input  logic               adc_measure_trig,
  input  logic               cmpr_val,
  input  logic [CNT_W-1:0]   p_clk_count_aperture,
  input  logic [SHORT_W-1:0] p_clk_count_reset,
  input  logic [SHORT_W-1:0] p_clk_count_fix,
  input  logic [SHORT_W-1:0] p_clk_count_var,
  input  logic               p_use_slow_rundown,
  input  logic               p_use_fast_rundown,
  output logic               adc_measure_valid,
  // reset, neg, pos switch bits
  output logic [2:0]         refmux,
  output logic               sigmux,
  output logic [SHORT_W-1:0] clk_count_refmux_reset_last,
  output logic [CNT_W-1:0]   clk_count_refmux_neg_last,
  output logic [CNT_W-1:0]   clk_count_refmux_pos_last,
  output logic [SHORT_W-1:0] clk_count_refmux_rd_last,
  output logic [CNT_W-1:0]   clk_count_mux_sig_last
);

  mod_ctl_if #(.CNT_W(CNT_W)) ctl ();

  ////////////////////////////////////////
  // blocks

  modulation_fsm u_fsm (
    .clk                (clk),
    .cmpr_latch_val     (cmpr_latch_val),
    .adc_measure_trig   (adc_measure_trig),
    .cmpr_val           (cmpr_val),
    .p_clk_count_reset  (p_clk_count_reset),
    .p_clk_count_fix    (p_clk_count_fix),
    .p_clk_count_var    (p_clk_count_var),
    .p_use_slow_rundown (p_use_slow_rundown),
    .p_use_fast_rundown (p_use_fast_rundown),
    .adc_measure_valid  (adc_measure_valid),
    .ctl                (ctl.fsm)
  );

  aperture_ctl #(.CNT_W(CNT_W)) u_aperture (
    .clk                  (clk),
    .cmpr_latch_val       (cmpr_latch_val),
    .p_clk_count_aperture (p_clk_count_aperture),
    .ctl                  (ctl.aperture)
  );

  dwell_counters #(.CNT_W(CNT_W)) u_counters (
    .clk                         (clk),
    .cmpr_latch_val              (cmpr_latch_val),
    .ctl                         (ctl.counters),
    .clk_count_refmux_reset_last (clk_count_refmux_reset_last),
    .clk_count_refmux_neg_last   (clk_count_refmux_neg_last),
    .clk_count_refmux_pos_last   (clk_count_refmux_pos_last),
    .clk_count_refmux_rd_last    (clk_count_refmux_rd_last),
    .clk_count_mux_sig_last      (clk_count_mux_sig_last)
  );

  // analog switches see the word as switch bits
  assign refmux = {ctl.refmux.sw.reset_sw, ctl.refmux.sw.neg_sw, ctl.refmux.sw.pos_sw};
  assign sigmux = ctl.sigmux;

endmodule

// File: tb/integrator_model.sv
`timescale 1ns/1ps

// behavioral integrator plus comparator, driven by the DUT switch outputs
module integrator_model #(
  parameter int REF_STEP = 256
) (
  input  logic       clk,
  // reset, neg, pos switch bits
  input  logic [2:0] refmux,
  input  logic       sigmux,
  input  int         sig_current,
  output logic       cmpr_val
);

  // integrator state in charge units
  longint value = 0;
  longint step;

  ////////////////////////////////////////
  // integration, once per clock

  // settles half a cycle before the DUT samples the comparator
  always @(negedge clk)
  begin
    step = sigmux ? longint'(sig_current) : 0;
    case (refmux[1:0])
      // pos ref alone pulls down
      2'b01: step = step - REF_STEP;
      // neg ref alone pushes up
      2'b10: step = step + REF_STEP;
      // both on, slow net pull down
      2'b11: step = step - REF_STEP / 16;
      default: ;
    endcase
    // reset switch shorts the cap
    if (refmux[2])
      value <= 0;
    else
      value <= value + step;
  end

  // high while below zero
  assign cmpr_val = (value < 0);

endmodule

// File: tb/adc_mod_assert.sv
`timescale 1ns/1ps

module adc_mod_assert
  import adc_pkg::*;
(
  input logic       clk,
  input logic       cmpr_latch_val,
  input logic [2:0] refmux,
  input logic       sigmux,
  input logic       adc_measure_valid,
  input mod_state_e state,
  input logic       capture
);

  ////////////////////////////////////////
  // mux word

  // only the five defined codes
  legal_refmux: assert property (@(posedge clk) disable iff (!cmpr_latch_val)
    refmux inside {REFMUX_NONE, REFMUX_POS, REFMUX_NEG, REFMUX_SLOW_POS, REFMUX_RESET})
    else $error("refmux holds illegal code %b", refmux);

  // signal gate closed while integrator is shorted
  no_sig_in_reset: assert property (@(posedge clk) disable iff (!cmpr_latch_val)
    (refmux == REFMUX_RESET) |-> !sigmux)
    else $error("sigmux high during reset code");

  ////////////////////////////////////////
  // valid level

  // low for the whole measurement
  valid_low_busy: assert property (@(posedge clk) disable iff (!cmpr_latch_val)
    !(state inside {ST_DONE, ST_RESET_START}) |-> !adc_measure_valid)
    else $error("adc_measure_valid high during measurement");

  // valid only comes back through the capture strobe
  valid_rise_on_capture: assert property (@(posedge clk) disable iff (!cmpr_latch_val)
    $rose(adc_measure_valid) |-> $past(capture))
    else $error("adc_measure_valid rose without capture");

endmodule

bind adc_mod_top adc_mod_assert u_assert (
  .clk               (clk),
  .cmpr_latch_val    (cmpr_latch_val),
  .refmux            (refmux),
  .sigmux            (sigmux),
  .adc_measure_valid (adc_measure_valid),
  .state             (u_fsm.state),
  .capture           (ctl.capture)
);

// File: tb/adc_mod_tb.sv
`timescale 1ns/1ps

module adc_mod_tb
  import adc_pkg::*;
();

  localparam int REF_STEP   = 256;
  localparam int N_ROWS     = 6;
  localparam int WAIT_LIMIT = 20000;

  // one measurement setup per row
  typedef struct packed {
    logic [CNT_W-1:0]   aperture;
    logic [SHORT_W-1:0] reset_cnt;
    logic [SHORT_W-1:0] fix_cnt;
    logic [SHORT_W-1:0] var_cnt;
    logic               slow;
    logic               fast;
    // retrigger mid measurement
    logic               restart;
    int                 current;
  } row_t;

  row_t rows [N_ROWS];

  logic clk;
  logic cmpr_latch_val;
  logic adc_measure_trig;
  logic cmpr_val;
  logic [CNT_W-1:0]   p_clk_count_aperture;
  logic [SHORT_W-1:0] p_clk_count_reset;
  logic [SHORT_W-1:0] p_clk_count_fix;
  logic [SHORT_W-1:0] p_clk_count_var;
  logic p_use_slow_rundown;
  logic p_use_fast_rundown;
  logic adc_measure_valid;
  logic [2:0] refmux;
  logic sigmux;
  logic [SHORT_W-1:0] clk_count_refmux_reset_last;
  logic [CNT_W-1:0]   clk_count_refmux_neg_last;
  logic [CNT_W-1:0]   clk_count_refmux_pos_last;
  logic [SHORT_W-1:0] clk_count_refmux_rd_last;
  logic [CNT_W-1:0]   clk_count_mux_sig_last;
  int sig_current;

  int checks = 0;
  int errors = 0;
  int timeouts = 0;
  int seed;

  adc_mod_top #(.CNT_W(CNT_W)) dut (.*);

  integrator_model #(.REF_STEP(REF_STEP)) u_integrator (
    .clk         (clk),
    .refmux      (refmux),
    .sigmux      (sigmux),
    .sig_current (sig_current),
    .cmpr_val    (cmpr_val)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////
  // helpers

  task automatic check_value(input string name, input longint got, input longint exp);
    checks++;
    if (got != exp)
    begin
      errors++;
      $display("ERR t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
    end
  endtask

  // one clock of trigger, seen at a single edge
  task automatic pulse_trigger();
    @(posedge clk);
    adc_measure_trig <= 1'b1;
    @(posedge clk);
    adc_measure_trig <= 1'b0;
  endtask

  task automatic wait_valid(input logic level, input string what, output bit ok);
    int n;
    n = 0;
    while (adc_measure_valid !== level && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    ok = (adc_measure_valid === level);
    if (!ok)
    begin
      timeouts++;
      $display("timeout at %0t: adc_measure_valid did not %s within %0d cycles",
               $time, what, WAIT_LIMIT);
    end
  endtask

  task automatic apply_row(input row_t r);
    @(posedge clk);
    p_clk_count_aperture <= r.aperture;
    p_clk_count_reset    <= r.reset_cnt;
    p_clk_count_fix      <= r.fix_cnt;
    p_clk_count_var      <= r.var_cnt;
    p_use_slow_rundown   <= r.slow;
    p_use_fast_rundown   <= r.fast;
    sig_current          <= r.current;
  endtask

  task automatic check_result(input row_t r);
    longint residual;
    // gate stays open one clock past the aperture
    check_value("clk_count_mux_sig_last", clk_count_mux_sig_last, r.aperture + 1);
    check_value("clk_count_refmux_reset_last", clk_count_refmux_reset_last, r.reset_cnt + 2);
    // leftover charge after rundown, within two reference steps
    residual = longint'(r.current) * longint'(clk_count_mux_sig_last)
             + REF_STEP * longint'(clk_count_refmux_neg_last)
             - REF_STEP * longint'(clk_count_refmux_pos_last)
             - (REF_STEP / 16) * longint'(clk_count_refmux_rd_last);
    checks++;
    if (residual > 2 * REF_STEP || residual < -2 * REF_STEP)
    begin
      errors++;
      $display("charge balance off at %0t: residual %0d exceeds %0d",
               $time, residual, 2 * REF_STEP);
    end
    checks++;
    if ((clk_count_refmux_rd_last != 0) != r.slow)
    begin
      errors++;
      $display("rundown count %0d does not match slow rundown flag %0b at %0t",
               clk_count_refmux_rd_last, r.slow, $time);
    end
  endtask

  task automatic run_row(input row_t r);
    bit ok;
    int delay;
    row_t cur;
    cur = r;
    apply_row(cur);
    pulse_trigger();
    wait_valid(1'b0, "fall", ok);
    if (ok && r.restart)
    begin
      delay = 20 + ($urandom % 40);
      repeat (delay) @(negedge clk);
      if (adc_measure_valid !== 1'b0)
      begin
        errors++;
        $display("measurement ended before the restart trigger at %0t", $time);
      end
      // longer reset for the second pass, only seen in the result if it restarted
      cur.reset_cnt = r.reset_cnt + 3;
      apply_row(cur);
      pulse_trigger();
    end
    if (ok)
      wait_valid(1'b1, "rise", ok);
    if (ok)
      check_result(cur);
  endtask

  ////////////////////////////////////////
  // stimulus table and main loop

  initial
  begin
    seed = $urandom(32'h5da6);
    cmpr_latch_val       = 1'b0;
    adc_measure_trig     = 1'b0;
    p_clk_count_aperture = '0;
    p_clk_count_reset    = '0;
    p_clk_count_fix      = '0;
    p_clk_count_var      = '0;
    p_use_slow_rundown   = 1'b0;
    p_use_fast_rundown   = 1'b0;
    sig_current          = 0;

    // non-fast rows are tuned to land in the rundown window after one runup cycle
    rows[0] = '{aperture: 9, reset_cnt: 3, fix_cnt: 2, var_cnt: 6,
                slow: 0, fast: 0, restart: 0, current: 200};
    rows[1] = '{aperture: 9, reset_cnt: 7, fix_cnt: 2, var_cnt: 6,
                slow: 1, fast: 0, restart: 0, current: 200};
    rows[2] = '{aperture: 100, reset_cnt: 5, fix_cnt: 3, var_cnt: 8,
                slow: 0, fast: 1, restart: 0, current: 150};
    rows[3] = '{aperture: 257, reset_cnt: 12, fix_cnt: 4, var_cnt: 9,
                slow: 1, fast: 1, restart: 0, current: -90};
    rows[4] = '{aperture: 64, reset_cnt: 0, fix_cnt: 1, var_cnt: 6,
                slow: 1, fast: 1, restart: 0, current: 120};
    rows[5] = '{aperture: 150, reset_cnt: 4, fix_cnt: 2, var_cnt: 7,
                slow: 0, fast: 1, restart: 1, current: -160};

    repeat (10) @(posedge clk);
    cmpr_latch_val <= 1'b1;
    @(negedge clk);
    // idle state straight out of reset
    check_value("adc_measure_valid", adc_measure_valid, 1);
    check_value("refmux", refmux, REFMUX_RESET);
    check_value("sigmux", sigmux, 0);
    check_value("clk_count_mux_sig_last", clk_count_mux_sig_last, 0);
    check_value("clk_count_refmux_reset_last", clk_count_refmux_reset_last, 0);
    check_value("clk_count_refmux_neg_last", clk_count_refmux_neg_last, 0);
    check_value("clk_count_refmux_pos_last", clk_count_refmux_pos_last, 0);
    check_value("clk_count_refmux_rd_last", clk_count_refmux_rd_last, 0);

    for (int i = 0; i < N_ROWS; i++)
      run_row(rows[i]);

    $display("checks=%0d errors=%0d timeouts=%0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: list.f
logic/adc_pkg.sv
logic/mod_ctl_if.sv
logic/modulation_fsm.sv
logic/aperture_ctl.sv
logic/dwell_counters.sv
logic/adc_mod_top.sv
tb/integrator_model.sv
tb/adc_mod_assert.sv
tb/adc_mod_tb.sv
